// File: verilog/video_pkg.sv
package video_pkg;

    // ####################
    // Widths
    typedef logic [9:0]  hcount_t;
    typedef logic [8:0]  vcount_t;
    typedef logic [7:0]  chan_t;
    typedef logic [15:0] frame_t;
    typedef logic [2:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // ####################
    // Raster geometry, 740 x 500 total
    localparam hcount_t h_total     = 10'd740;
    localparam vcount_t v_total     = 9'd500;
    localparam hcount_t h_sync      = 10'd50;
    localparam vcount_t v_sync      = 9'd50;
    localparam hcount_t h_act_start = 10'd100;
    localparam hcount_t h_act_end   = 10'd500;
    localparam vcount_t v_act_start = 9'd100;
    localparam vcount_t v_act_end   = 9'd460;
    localparam hcount_t bar_width   = 10'd50;   // Eight bars across 400 pixels

    // ####################
    // Register map, word addresses
    localparam wb_addr_t reg_ctrl   = 3'd0;   // bit0 enable, bit1 half_width, 3:2 pattern
    localparam wb_addr_t reg_step   = 3'd1;
    localparam wb_addr_t reg_solid  = 3'd2;
    localparam wb_addr_t reg_frames = 3'd3;   // Read only

    typedef enum logic [1:0] {
        pat_ramp  = 2'd0,
        pat_solid = 2'd1,
        pat_bars  = 2'd2
    } pattern_e;

    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_t;

    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic skip;
        logic vs;
        logic hs;
    } video_bus_t;

    typedef struct packed {
        hcount_t hcount;
        vcount_t vcount;
        logic    active;
        logic    hs;
        logic    vs;
    } raster_t;

    typedef struct packed {
        logic     enable;
        logic     half_width;
        pattern_e pattern;
        chan_t    step;
        rgb_t     solid;
    } config_t;

endpackage

// File: verilog/video_timing.sv
`timescale 1ns/10ps

module video_timing (
    input  logic              video,
    input  logic              rst,
    output video_pkg::raster_t raster
);
    import video_pkg::*;

    hcount_t hcount;
    vcount_t vcount;
    logic    line_end;
    logic    frame_end;
    logic    h_active;
    logic    v_active;
    logic    hs_next;
    logic    vs_next;

    // ####################
    // Free running counters
    assign line_end  = hcount == hcount_t'(h_total - 10'd1);
    assign frame_end = vcount == vcount_t'(v_total - 9'd1);

    always_ff @(posedge video) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
            if (frame_end) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 9'd1;
            end
        end else begin
            hcount <= hcount + 10'd1;
        end
    end

    // ####################
    // Sync and window decode
    assign h_active = (hcount >= h_act_start) && (hcount < h_act_end);
    assign v_active = (vcount >= v_act_start) && (vcount < v_act_end);

    assign hs_next = hcount == h_sync;                        // Once per line
    assign vs_next = (vcount == v_sync) && (hcount == h_sync); // Single clock per frame

    always_ff @(posedge video) begin
        if (rst) begin
            raster <= '0;
        end else begin
            raster.hcount <= hcount;
            raster.vcount <= vcount;
            raster.active <= h_active && v_active;
            raster.hs     <= hs_next;
            raster.vs     <= vs_next;
        end
    end

    // Sync pulse sits in the blanking before the window
    hs_outside_active: assert property (
        @(posedge video) disable iff (rst) !(raster.active && raster.hs)
    );

endmodule

// File: verilog/video_pattern.sv
`timescale 1ns/10ps

module video_pattern (
    input  logic                 video,
    input  logic                 rst,
    input  video_pkg::raster_t   raster,
    input  video_pkg::config_t   cfg,
    output video_pkg::video_bus_t pixel
);
    import video_pkg::*;

    rgb_t       ramp;
    rgb_t       bar_rgb;
    rgb_t       colour;
    logic [2:0] bar_num;

    function automatic chan_t sat_add(chan_t a, chan_t b);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[8] ? 8'hff : sum[7:0];
    endfunction

    // ####################
    // Colour ramp, red then green then blue
    always_ff @(posedge video) begin
        if (rst || !raster.active) begin
            ramp <= '0;   // Each line starts black
        end else if (ramp.red < 8'd254) begin
            ramp.red <= sat_add(ramp.red, cfg.step);
        end else if (ramp.green < 8'd254) begin
            ramp.green <= sat_add(ramp.green, cfg.step);
        end else if (ramp.blue < 8'd254) begin
            ramp.blue <= sat_add(ramp.blue, cfg.step);
        end
    end

    // ####################
    // Vertical bars
    always_comb begin
        bar_num       = 3'((raster.hcount - h_act_start) / bar_width);
        bar_rgb.red   = {8{bar_num[2]}};
        bar_rgb.green = {8{bar_num[1]}};
        bar_rgb.blue  = {8{bar_num[0]}};
    end

    always_comb begin
        if (!raster.active) begin
            colour = '0;
        end else begin
            case (cfg.pattern)
                pat_ramp:  colour = ramp;
                pat_solid: colour = cfg.solid;
                pat_bars:  colour = bar_rgb;
                default:   colour = '0;   // Unused code
            endcase
        end
    end

    always_ff @(posedge video) begin
        if (rst) begin
            pixel <= '0;
        end else begin
            pixel.rgb  <= colour;
            pixel.de   <= raster.active;
            pixel.skip <= 1'b0;   // Set later in the output stage
            pixel.hs   <= raster.hs;
            pixel.vs   <= raster.vs;
        end
    end

endmodule

// File: verilog/video_regs.sv
`timescale 1ns/10ps

module video_regs (
    input  logic               video,
    input  logic               rst,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  video_pkg::wb_addr_t adr,
    input  video_pkg::wb_data_t dat_w,
    output video_pkg::wb_data_t dat_r,
    output logic               ack,
    input  video_pkg::raster_t  raster,
    output video_pkg::config_t  cfg
);
    import video_pkg::*;

    config_t  shadow;
    frame_t   frames;
    wb_data_t rd_data;
    logic     req;
    logic     at_origin;
    logic     at_origin_q;
    logic     frame_start;

    // New request only while ack is low, so ack is a single pulse
    assign req = cyc && stb && !ack;

    always_ff @(posedge video) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    // ####################
    // Shadow registers
    always_ff @(posedge video) begin
        if (rst) begin
            shadow <= '0;
        end else if (req && we) begin
            case (adr)
                reg_ctrl: begin
                    shadow.enable     <= dat_w[0];
                    shadow.half_width <= dat_w[1];
                    shadow.pattern    <= pattern_e'(dat_w[3:2]);
                end
                reg_step:  shadow.step  <= dat_w[7:0];
                reg_solid: shadow.solid <= dat_w[23:0];
                default: ;   // frames is read only
            endcase
        end
    end

    always_comb begin
        case (adr)
            reg_ctrl:   rd_data = {28'd0, shadow.pattern, shadow.half_width, shadow.enable};
            reg_step:   rd_data = {24'd0, shadow.step};
            reg_solid:  rd_data = {8'd0, shadow.solid};
            reg_frames: rd_data = {16'd0, frames};
            default:    rd_data = '0;
        endcase
    end

    always_ff @(posedge video) begin
        if (req && !we) begin
            dat_r <= rd_data;   // Valid in the ack cycle
        end
    end

    // ####################
    // Frame start
    assign at_origin   = (raster.hcount == '0) && (raster.vcount == '0);
    assign frame_start = at_origin && !at_origin_q;   // Raster sits at origin twice out of reset

    always_ff @(posedge video) begin
        if (rst) begin
            at_origin_q <= 1'b0;
            frames      <= '0;
            cfg         <= '0;
        end else begin
            at_origin_q <= at_origin;
            if (frame_start) begin
                frames <= frames + 16'd1;
                cfg    <= shadow;
            end
        end
    end

    ack_after_request: assert property (
        @(posedge video) disable iff (rst) ack |-> $past(cyc && stb)
    );

endmodule

// File: verilog/video_out.sv
`timescale 1ns/10ps

module video_out (
    input  logic                  video,
    input  logic                  rst,
    input  video_pkg::config_t    cfg,
    input  video_pkg::video_bus_t pixel,
    output video_pkg::video_bus_t video_out
);
    import video_pkg::*;

    logic phase;   // High on odd pixel count within the line
    logic show;

    assign show = cfg.enable && pixel.de;

    always_ff @(posedge video) begin
        if (rst) begin
            phase     <= 1'b0;
            video_out <= '0;
        end else begin
            phase <= pixel.de ? !phase : 1'b0;

            // Syncs run regardless of enable
            video_out.hs <= pixel.hs;
            video_out.vs <= pixel.vs;

            video_out.de   <= show;
            video_out.rgb  <= cfg.enable ? pixel.rgb : rgb_t'('0);
            video_out.skip <= show && cfg.half_width && phase;
        end
    end

    // A line has an even number of pixels so the phase is back to zero at blanking
    phase_clear_in_blank: assert property (
        @(posedge video) disable iff (rst) $fell(pixel.de) |-> !phase
    );

endmodule

// File: verilog/video_top.sv
`timescale 1ns/10ps

module video_top (
    input  logic                  video,
    input  logic                  rst,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  video_pkg::wb_addr_t   adr,
    input  video_pkg::wb_data_t   dat_w,
    output video_pkg::wb_data_t   dat_r,
    output logic                  ack,
    output video_pkg::video_bus_t video_out
);
    import video_pkg::*;

    raster_t    raster;
    config_t    cfg;
    video_bus_t pixel;

    video_regs regs (
        .video (video),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .raster(raster),
        .cfg   (cfg)
    );

    video_timing timing (
        .video (video),
        .rst   (rst),
        .raster(raster)
    );

    video_pattern pattern (
        .video (video),
        .rst   (rst),
        .raster(raster),
        .cfg   (cfg),
        .pixel (pixel)
    );

    video_out out_stage (
        .video    (video),
        .rst      (rst),
        .cfg      (cfg),
        .pixel    (pixel),
        .video_out(video_out)
    );

endmodule

// File: test/video_tb.sv
`timescale 1ns/10ps

module video_tb;
    import video_pkg::*;

    typedef struct packed {
        logic [3:0] ctrl;
        chan_t      step;
        rgb_t       solid;
        rgb_t       px0;
        rgb_t       px1;
        rgb_t       px2;
        rgb_t       px_last;
        hcount_t    skips;   // Per line
        hcount_t    lines;
    } case_t;

    localparam int frame_cycles = int'(h_total) * int'(v_total);
    localparam int line_cycles  = int'(h_total);
    localparam int line_pixels  = int'(h_act_end - h_act_start);
    localparam int last_px      = line_pixels - 1;
    // From the vs pulse to the last active pixel of the same frame
    localparam int last_offset  = int'(v_act_end - v_sync - 9'd1) * line_cycles
                                  + int'(h_act_end - h_sync - 10'd1);
    localparam int window       = last_offset + 16;
    localparam int window_hs    = window / line_cycles + 1;
    localparam int write_delay  = frame_cycles / 3;   // Lands inside the active lines

    logic       video;
    logic       rst;
    logic       cyc;
    logic       stb;
    logic       we;
    wb_addr_t   adr;
    wb_data_t   dat_w;
    wb_data_t   dat_r;
    logic       ack;
    video_bus_t video_out;

    case_t cases[$];
    string names[$];
    int    cycles;
    int    limit;

    video_top DUT (
        .video    (video),
        .rst      (rst),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_w    (dat_w),
        .dat_r    (dat_r),
        .ack      (ack),
        .video_out(video_out)
    );

    initial video = 1'b0;
    always #10 video = ~video;

    always @(posedge video) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            fail_run("Simulation hung, cycle limit reached");
        end
    end

    // ####################
    // Reporting
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
        if (expected !== actual) begin
            fail_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input hcount_t expected, input hcount_t actual);
        if (expected !== actual) begin
            fail_run($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_word(input string name, input wb_data_t expected,
                              input wb_data_t actual);
        if (expected !== actual) begin
            fail_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic string pixel_name(input string name, input hcount_t line, input int px);
        return $sformatf("%s line %0d pixel %0d", name, line, px);
    endfunction

    // ####################
    // Wishbone master
    task automatic bus_cycle(input logic write, input wb_addr_t addr, input wb_data_t wdata,
                             output wb_data_t rdata);
        @(posedge video);
        #2;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        @(negedge video);
        if (ack) begin
            fail_run("Bus ack came in the same cycle as the request");
        end
        @(negedge video);
        if (!ack) begin
            fail_run("Bus ack missing in the cycle after the request");
        end
        rdata = dat_r;   // Read data is valid with ack
        @(posedge video);
        #2;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        @(negedge video);
        if (ack) begin
            fail_run("Bus ack stayed high for more than one cycle");
        end
    endtask

    task automatic bus_write(input wb_addr_t addr, input wb_data_t data);
        wb_data_t unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input wb_addr_t addr, output wb_data_t data);
        bus_cycle(1'b0, addr, '0, data);
    endtask

    task automatic load_case(input case_t c);
        bus_write(reg_step, {24'd0, c.step});
        bus_write(reg_solid, {8'd0, c.solid});
        bus_write(reg_ctrl, {28'd0, c.ctrl});
    endtask

    // ####################
    // Frame measurement
    task automatic wait_vs();
        @(negedge video);
        while (!video_out.vs) begin
            @(negedge video);
        end
    endtask

    // Starts on the vs cycle and runs up to the next vs
    task automatic check_blank_frame();
        int      n;
        int      last_hs;
        hcount_t hs_seen;
        last_hs = 0;   // hs and vs share the first cycle
        hs_seen = '0;
        for (n = 1; n <= frame_cycles; n++) begin
            @(negedge video);
            if (video_out.de || video_out.skip) begin
                fail_run("de or skip went high while the display was disabled");
            end
            check_rgb("blank frame rgb", '0, video_out.rgb);
            if (video_out.hs) begin
                check_count("hs period", hcount_t'(line_cycles), hcount_t'(n - last_hs));
                last_hs = n;
                hs_seen++;
            end
            if (video_out.vs != (n == frame_cycles)) begin
                fail_run($sformatf("vs pulse out of place, %0d cycles after the last one", n));
            end
        end
        check_count("hs pulses per frame", hcount_t'(v_total), hs_seen);
    endtask

    task automatic check_picture(input int idx);
        case_t   c;
        string   name;
        int      n;
        int      px;   // Pixel index within the line
        hcount_t lines;
        hcount_t skips;
        hcount_t syncs;
        logic    de_q;
        c     = cases[idx];
        name  = names[idx];
        px    = 0;
        lines = '0;
        skips = '0;
        syncs = 10'd1;
        de_q  = 1'b0;
        for (n = 1; n <= window; n++) begin
            @(negedge video);
            if (video_out.hs) begin
                syncs++;
            end
            if (video_out.vs) begin
                fail_run($sformatf("Second vs pulse inside one frame in %s", name));
            end
            if (video_out.skip && !video_out.de) begin
                fail_run($sformatf("skip set outside de in %s", name));
            end
            if (video_out.de) begin
                if (video_out.skip) begin
                    skips++;
                    if (px % 2 == 0) begin
                        fail_run($sformatf("skip on an odd-numbered pixel in %s", name));
                    end
                end
                case (px)
                    0:       check_rgb(pixel_name(name, lines, px), c.px0, video_out.rgb);
                    1:       check_rgb(pixel_name(name, lines, px), c.px1, video_out.rgb);
                    2:       check_rgb(pixel_name(name, lines, px), c.px2, video_out.rgb);
                    last_px: check_rgb(pixel_name(name, lines, px), c.px_last, video_out.rgb);
                    default: ;
                endcase
                px++;
            end else begin
                check_rgb({name, " blanking rgb"}, '0, video_out.rgb);
                if (de_q) begin   // Line just ended
                    check_count({name, " de per line"}, hcount_t'(line_pixels), hcount_t'(px));
                    check_count({name, " skips per line"}, c.skips, skips);
                    lines++;
                    px    = 0;
                    skips = '0;
                end
            end
            de_q = video_out.de;
        end
        check_count({name, " lines"}, c.lines, lines);
        check_count({name, " hs pulses"}, hcount_t'(window_hs), syncs);
    endtask

    // ####################
    // Stimulus table
    task automatic add_case(input string name, input logic [3:0] ctrl, input chan_t step,
                            input rgb_t solid, input rgb_t px0, input rgb_t px1,
                            input rgb_t px2, input rgb_t px_last, input hcount_t skips,
                            input hcount_t lines);
        case_t c;
        c.ctrl    = ctrl;
        c.step    = step;
        c.solid   = solid;
        c.px0     = px0;
        c.px1     = px1;
        c.px2     = px2;
        c.px_last = px_last;
        c.skips   = skips;
        c.lines   = lines;
        cases.push_back(c);
        names.push_back(name);
    endtask

    task automatic build_table();
        // Red climbs to 254 by step 1, then green carries on
        add_case("ramp_step_1", 4'h1, 8'd1, 24'h000000,
                 24'h000000, 24'h010000, 24'h020000, 24'hfe9100, 10'd0, 10'd360);
        add_case("ramp_step_10_half", 4'h3, 8'd10, 24'h000000,
                 24'h000000, 24'h0a0000, 24'h140000, 24'hffffff, 10'd200, 10'd360);
        add_case("solid_half", 4'h7, 8'd0, 24'h3c5a96,
                 24'h3c5a96, 24'h3c5a96, 24'h3c5a96, 24'h3c5a96, 10'd200, 10'd360);
        add_case("bars", 4'h9, 8'd0, 24'h000000,
                 24'h000000, 24'h000000, 24'h000000, 24'hffffff, 10'd0, 10'd360);
        add_case("disabled", 4'h6, 8'd5, 24'hffffff,
                 24'h000000, 24'h000000, 24'h000000, 24'h000000, 10'd0, 10'd0);
    endtask

    // ####################
    // Main sequence
    initial begin
        wb_data_t frames_a;
        wb_data_t frames_b;
        wb_data_t word;
        int       i;
        rst    = 1'b1;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_w  = '0;
        cycles = 0;
        build_table();
        limit  = (cases.size() + 3) * frame_cycles + 1000;

        repeat (3) @(posedge video);
        #2;
        rst = 1'b0;

        // Readback, the enable written here must stay hidden until frame 1
        bus_write(reg_step, 32'h0000_005a);
        bus_write(reg_solid, 32'h0012_ab7f);
        bus_write(reg_ctrl, 32'h0000_0009);
        bus_read(reg_step, word);
        check_word("step readback", 32'h0000_005a, word);
        bus_read(reg_solid, word);
        check_word("solid readback", 32'h0012_ab7f, word);
        bus_read(reg_ctrl, word);
        check_word("ctrl readback", 32'h0000_0009, word);

        wait_vs();
        fork
            check_blank_frame();
            bus_read(reg_frames, frames_a);
        join
        bus_read(reg_frames, frames_b);
        check_word("frames after reset", 32'd1, frames_a);
        check_word("frames per vs period", 32'd2, frames_b);

        load_case(cases[0]);
        for (i = 0; i < cases.size(); i++) begin
            wait_vs();
            fork
                check_picture(i);
                begin
                    // Next row goes in mid frame and must wait for the frame start
                    if (i + 1 < cases.size()) begin
                        repeat (write_delay) @(posedge video);
                        load_case(cases[i + 1]);
                    end
                end
            join
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: all.f
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/video_pattern.sv
verilog/video_regs.sv
verilog/video_out.sv
verilog/video_top.sv
test/video_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the video testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module video_tb \
    -f all.f

./obj_dir/Vvideo_tb | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
